/* source/wb_xbar_pkg.sv */
/*
 * Wishbone crossbar shared definitions
 * Bus widths, address map of the four slave windows, target indices
 * and the request and response structs carried between the ports
 */

`default_nettype none

package wb_xbar_pkg;

	// Bus widths
	localparam int ADR_W = 32;
	localparam int DAT_W = 32;
	localparam int SEL_W = DAT_W / 8;

	// Crossbar size
	localparam int N_MASTERS = 2;
	localparam int N_SLAVES = 4;
	// External slaves plus the decode-error target
	localparam int N_TARGETS = N_SLAVES + 1;

	typedef logic [ADR_W-1:0] wb_adr_t;
	typedef logic [DAT_W-1:0] wb_dat_t;
	typedef logic [SEL_W-1:0] wb_sel_t;

	// Target index 0..4, or all ones when nothing is selected
	typedef logic [2:0] tgt_id_t;

	// One bit per master, one-hot or zero
	typedef logic [N_MASTERS-1:0] mst_vec_t;

	localparam tgt_id_t ERR_TARGET = 3'd4;
	localparam tgt_id_t NO_TARGET = 3'b111;

	// Four 4 KiB windows at the bottom of the address space
	localparam wb_adr_t SLAVE_BASE [N_SLAVES] = '{
		32'h0000_0000,
		32'h0000_1000,
		32'h0000_2000,
		32'h0000_3000
	};

	// Last byte of each window
	localparam wb_adr_t SLAVE_LIMIT [N_SLAVES] = '{
		32'h0000_0FFF,
		32'h0000_1FFF,
		32'h0000_2FFF,
		32'h0000_3FFF
	};

	// Master to slave direction, 71 bits
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		wb_adr_t adr;
		wb_sel_t sel;
		wb_dat_t dat_w;
	} wb_req_t;

	// Slave to master direction, 34 bits
	typedef struct packed {
		logic ack;
		logic err;
		wb_dat_t dat_r;
	} wb_rsp_t;

endpackage

`default_nettype wire

/* source/wb_rr_arbiter.sv */
/*
 * Round-robin arbiter
 * Registered one-hot grant, held until the granted request drops,
 * then one idle cycle before the next pick
 */

`timescale 1ns/1ps
`default_nettype none

module wb_rr_arbiter #(
	parameter int N_REQ = 2
) (
	input wire logic clk,
	input wire logic rstn,
	input wire logic [N_REQ-1:0] req_i,
	output logic [N_REQ-1:0] gnt_o
);

	typedef enum logic {
		ST_IDLE,
		ST_GRANT
	} arb_state_t;

	arb_state_t state_q;

	// Requester that won the previous arbitration
	logic [N_REQ-1:0] last_gnt_q;

	// Set once the search has passed the last granted bit
	logic above;
	// First request strictly above the last grant
	logic [N_REQ-1:0] masked_pick;
	// Lowest request, used when nothing sits above the last grant
	logic [N_REQ-1:0] unmasked_pick;
	logic [N_REQ-1:0] pick;

	// Priority search over the request vector
	always_comb begin
		above = 1'b0;
		masked_pick = '0;
		unmasked_pick = '0;
		for (int i = 0; i < N_REQ; i++) begin
			if (req_i[i] && above && (masked_pick == '0)) begin
				masked_pick[i] = 1'b1;
			end
			if (req_i[i] && (unmasked_pick == '0)) begin
				unmasked_pick[i] = 1'b1;
			end
			// Bits after this one count as above the last grant
			if (last_gnt_q[i]) begin
				above = 1'b1;
			end
		end
	end

	// Wrap around to the lowest requester when needed
	assign pick = (masked_pick != '0) ? masked_pick : unmasked_pick;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state_q <= ST_IDLE;
			last_gnt_q <= '0;
			gnt_o <= '0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					// Grant one cycle after a request shows up
					if (pick != '0) begin
						state_q <= ST_GRANT;
						gnt_o <= pick;
						last_gnt_q <= pick;
					end
				end
				ST_GRANT: begin
					// Release once the owner withdraws
					if ((gnt_o & req_i) == '0) begin
						state_q <= ST_IDLE;
						gnt_o <= '0;
					end
				end
				default: begin
					state_q <= ST_IDLE;
					gnt_o <= '0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/wb_master_port.sv */
/*
 * Crossbar master port
 * Decodes the address of a new strobe against the window map, holds
 * the selected target until ack or err, and returns that target's
 * response while this master owns its grant
 */

`timescale 1ns/1ps
`default_nettype none

module wb_master_port (
	input wire logic clk,
	input wire logic rstn,
	input wire wb_xbar_pkg::wb_req_t req_i,
	output wb_xbar_pkg::wb_rsp_t rsp_o,
	output wb_xbar_pkg::tgt_id_t tgt_sel_o,
	input wire wb_xbar_pkg::wb_rsp_t tgt_rsp_i [wb_xbar_pkg::N_TARGETS],
	input wire logic [wb_xbar_pkg::N_TARGETS-1:0] granted_i
);

	// Selected target, NO_TARGET while idle
	wb_xbar_pkg::tgt_id_t tgt_sel_q;
	logic idle;
	// Response of the selected target, gated by grant
	wb_xbar_pkg::wb_rsp_t sel_rsp;

	// Map an address to a slave index, unmapped goes to the error target
	function automatic wb_xbar_pkg::tgt_id_t decode_target(
		input wb_xbar_pkg::wb_adr_t adr
	);
		wb_xbar_pkg::tgt_id_t tgt;

		tgt = wb_xbar_pkg::ERR_TARGET;
		for (int s = 0; s < wb_xbar_pkg::N_SLAVES; s++) begin
			if ((adr >= wb_xbar_pkg::SLAVE_BASE[s]) &&
					(adr <= wb_xbar_pkg::SLAVE_LIMIT[s])) begin
				tgt = wb_xbar_pkg::tgt_id_t'(s);
			end
		end
		return tgt;
	endfunction

	assign idle = (tgt_sel_q == wb_xbar_pkg::NO_TARGET);

	// Response mux
	always_comb begin
		sel_rsp = '0;
		for (int t = 0; t < wb_xbar_pkg::N_TARGETS; t++) begin
			// Only pass through while this master holds the target
			if ((tgt_sel_q == wb_xbar_pkg::tgt_id_t'(t)) && granted_i[t]) begin
				sel_rsp = tgt_rsp_i[t];
			end
		end
	end

	// Target select register
	always_ff @(posedge clk) begin
		if (!rstn) begin
			tgt_sel_q <= wb_xbar_pkg::NO_TARGET;
		end else if (idle) begin
			// Capture the decode on the first sampled strobe
			if (req_i.cyc && req_i.stb) begin
				tgt_sel_q <= decode_target(req_i.adr);
			end
		end else if (sel_rsp.ack || sel_rsp.err) begin
			// Transfer done, back to idle
			tgt_sel_q <= wb_xbar_pkg::NO_TARGET;
		end
	end

	assign rsp_o = sel_rsp;
	assign tgt_sel_o = tgt_sel_q;

endmodule

`default_nettype wire

/* source/wb_slave_port.sv */
/*
 * Crossbar slave port
 * Arbitrates among the masters that selected this target and forwards
 * the granted master's request
 */

`timescale 1ns/1ps
`default_nettype none

module wb_slave_port #(
	parameter int TARGET_ID = 0
) (
	input wire logic clk,
	input wire logic rstn,
	input wire wb_xbar_pkg::wb_req_t m_req_i [wb_xbar_pkg::N_MASTERS],
	input wire wb_xbar_pkg::tgt_id_t m_tgt_sel_i [wb_xbar_pkg::N_MASTERS],
	output wb_xbar_pkg::mst_vec_t gnt_o,
	output wb_xbar_pkg::wb_req_t t_req_o
);

	// Masters currently pointing at this target
	wb_xbar_pkg::mst_vec_t req;
	wb_xbar_pkg::mst_vec_t gnt;

	always_comb begin
		for (int m = 0; m < wb_xbar_pkg::N_MASTERS; m++) begin
			req[m] = (m_tgt_sel_i[m] == wb_xbar_pkg::tgt_id_t'(TARGET_ID));
		end
	end

	wb_rr_arbiter #(
		.N_REQ(wb_xbar_pkg::N_MASTERS)
	) arb0 (
		.clk(clk),
		.rstn(rstn),
		.req_i(req),
		.gnt_o(gnt)
	);

	// Request mux, grant is one-hot
	always_comb begin
		t_req_o = '0;
		for (int m = 0; m < wb_xbar_pkg::N_MASTERS; m++) begin
			// A lingering grant must not pass an unrelated strobe
			if (gnt[m] && req[m]) begin
				t_req_o = m_req_i[m];
			end
		end
	end

	assign gnt_o = gnt;

endmodule

`default_nettype wire

/* source/wb_decode_err.sv */
/*
 * Decode-error target
 * Answers any strobe outside the address map with a single
 * registered err pulse, no ack and zero read data
 */

`timescale 1ns/1ps
`default_nettype none

module wb_decode_err (
	input wire logic clk,
	input wire logic rstn,
	input wire wb_xbar_pkg::wb_req_t req_i,
	output wb_xbar_pkg::wb_rsp_t rsp_o
);

	logic err_q;

	// One pulse per strobe, the strobe is still up on the cycle after err
	always_ff @(posedge clk) begin
		if (!rstn) begin
			err_q <= 1'b0;
		end else begin
			err_q <= req_i.cyc && req_i.stb && !err_q;
		end
	end

	assign rsp_o.ack = 1'b0;
	assign rsp_o.err = err_q;
	// Nothing to read here
	assign rsp_o.dat_r = '0;

endmodule

`default_nettype wire

/* source/wb_xbar_2x4.sv */
/*
 * Wishbone crossbar, two masters by four slaves
 * Each master port decodes its own address, each target has its own
 * round-robin arbiter, unmapped accesses end at the error target
 */

`timescale 1ns/1ps
`default_nettype none

module wb_xbar_2x4 (
	input wire logic clk,
	input wire logic rstn,
	input wire wb_xbar_pkg::wb_req_t m_req_i [wb_xbar_pkg::N_MASTERS],
	output wb_xbar_pkg::wb_rsp_t m_rsp_o [wb_xbar_pkg::N_MASTERS],
	output wb_xbar_pkg::wb_req_t s_req_o [wb_xbar_pkg::N_SLAVES],
	input wire wb_xbar_pkg::wb_rsp_t s_rsp_i [wb_xbar_pkg::N_SLAVES]
);

	// Selected target per master
	wb_xbar_pkg::tgt_id_t tgt_sel [wb_xbar_pkg::N_MASTERS];

	// Grant vector per target, one bit per master
	wb_xbar_pkg::mst_vec_t tgt_gnt [wb_xbar_pkg::N_TARGETS];

	// Same grants seen from each master, one bit per target
	logic [wb_xbar_pkg::N_TARGETS-1:0] granted [wb_xbar_pkg::N_MASTERS];

	// Forwarded requests and target responses, index 4 is the error target
	wb_xbar_pkg::wb_req_t tgt_req [wb_xbar_pkg::N_TARGETS];
	wb_xbar_pkg::wb_rsp_t tgt_rsp [wb_xbar_pkg::N_TARGETS];

	// Transpose the grant matrix
	for (genvar m = 0; m < wb_xbar_pkg::N_MASTERS; m++) begin : g_gnt_m
		for (genvar t = 0; t < wb_xbar_pkg::N_TARGETS; t++) begin : g_gnt_t
			assign granted[m][t] = tgt_gnt[t][m];
		end
	end

	// Master side
	for (genvar m = 0; m < wb_xbar_pkg::N_MASTERS; m++) begin : g_mport
		wb_master_port mport (
			.clk(clk),
			.rstn(rstn),
			.req_i(m_req_i[m]),
			.rsp_o(m_rsp_o[m]),
			.tgt_sel_o(tgt_sel[m]),
			.tgt_rsp_i(tgt_rsp),
			.granted_i(granted[m])
		);
	end

	// Target side, external slaves and the error target alike
	for (genvar t = 0; t < wb_xbar_pkg::N_TARGETS; t++) begin : g_sport
		wb_slave_port #(
			.TARGET_ID(t)
		) sport (
			.clk(clk),
			.rstn(rstn),
			.m_req_i(m_req_i),
			.m_tgt_sel_i(tgt_sel),
			.gnt_o(tgt_gnt[t]),
			.t_req_o(tgt_req[t])
		);
	end

	// External slaves
	for (genvar s = 0; s < wb_xbar_pkg::N_SLAVES; s++) begin : g_slave
		assign s_req_o[s] = tgt_req[s];
		assign tgt_rsp[s] = s_rsp_i[s];
	end

	// Catches everything outside the map
	wb_decode_err derr0 (
		.clk(clk),
		.rstn(rstn),
		.req_i(tgt_req[wb_xbar_pkg::ERR_TARGET]),
		.rsp_o(tgt_rsp[wb_xbar_pkg::ERR_TARGET])
	);

endmodule

`default_nettype wire

/* verif/wb_mem_slave.sv */
/*
 * Behavioral Wishbone slave for the crossbar testbench
 * Sixteen-word memory with byte selects and a registered one-cycle ack
 */

`timescale 1ns/1ps
`default_nettype none

module wb_mem_slave #(
	parameter int SLAVE_ID = 0
) (
	input wire logic clk,
	input wire logic rstn,
	input wire wb_xbar_pkg::wb_req_t req_i,
	output wb_xbar_pkg::wb_rsp_t rsp_o
);

	wb_xbar_pkg::wb_dat_t mem [16];
	logic ack_q;
	wb_xbar_pkg::wb_dat_t dat_q;
	// Word index from address bits 5:2
	logic [3:0] idx;

	assign idx = req_i.adr[5:2];

	always_ff @(posedge clk) begin
		if (!rstn) begin
			ack_q <= 1'b0;
			dat_q <= '0;
			// Fill pattern from slave number and word index
			for (int w = 0; w < 16; w++) begin
				mem[w] <= 32'hC0DE_0000 | (32'(SLAVE_ID) << 8) | 32'(w);
			end
		end else begin
			// One ack per strobe
			ack_q <= req_i.cyc && req_i.stb && !ack_q;
			if (req_i.cyc && req_i.stb && !ack_q) begin
				if (req_i.we) begin
					for (int b = 0; b < 4; b++) begin
						if (req_i.sel[b]) begin
							mem[idx][8*b +: 8] <= req_i.dat_w[8*b +: 8];
						end
					end
				end
				dat_q <= mem[idx];
			end
		end
	end

	assign rsp_o.ack = ack_q;
	assign rsp_o.err = 1'b0;
	assign rsp_o.dat_r = dat_q;

endmodule

`default_nettype wire

/* verif/tb_wb_xbar.sv */
/*
 * Testbench for the two-master Wishbone crossbar
 * Four memory slaves, two task-driven masters, concurrent assertions on
 * reset, data, decode errors, routing, latency and arbitration order
 */

`timescale 1ns/1ps
`default_nettype none

module tb_wb_xbar;

	localparam int unsigned SEED = 32'h8da6_6c98;
	localparam int MEM_WORDS = 16;
	// About twenty times the length of all tests
	localparam int CYCLE_LIMIT = 4000;

	logic clk = 1'b0;
	logic rstn;
	wb_xbar_pkg::wb_req_t m_req [wb_xbar_pkg::N_MASTERS];
	wb_xbar_pkg::wb_rsp_t m_rsp [wb_xbar_pkg::N_MASTERS];
	wb_xbar_pkg::wb_req_t s_req [wb_xbar_pkg::N_SLAVES];
	wb_xbar_pkg::wb_rsp_t s_rsp [wb_xbar_pkg::N_SLAVES];

	// Expected memory contents
	wb_xbar_pkg::wb_dat_t shadow [wb_xbar_pkg::N_SLAVES][MEM_WORDS];
	string test_name;
	logic contend;
	logic par_done;
	// Current transfer per master
	logic [1:0] busy;
	logic [1:0] exp_err;
	logic [1:0] exp_we;
	wb_xbar_pkg::wb_dat_t exp_dat [wb_xbar_pkg::N_MASTERS];
	// Edges since each strobe was first sampled
	logic [7:0] lat_q [wb_xbar_pkg::N_MASTERS];
	logic last_ack_q;
	logic par_seen_q;
	int cyc_cnt = 0;
	int stb_cnt;
	int from_cnt [wb_xbar_pkg::N_MASTERS];

	always #4 clk = ~clk;

	wb_xbar_2x4 dut0 (
		.clk(clk),
		.rstn(rstn),
		.m_req_i(m_req),
		.m_rsp_o(m_rsp),
		.s_req_o(s_req),
		.s_rsp_i(s_rsp)
	);

	for (genvar s = 0; s < wb_xbar_pkg::N_SLAVES; s++) begin : g_mem
		wb_mem_slave #(
			.SLAVE_ID(s)
		) mem (
			.clk(clk),
			.rstn(rstn),
			.req_i(s_req[s]),
			.rsp_o(s_rsp[s])
		);
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1, "run stopped");
	endtask

	task automatic report_mismatch(input string what, input logic [127:0] exp,
			input logic [127:0] act);
		abort_run($sformatf("[ERROR] %s: %s expected %0h actual %0h",
			test_name, what, exp, act));
	endtask

	// Initial memory word, same rule as the slave reset fill
	function automatic wb_xbar_pkg::wb_dat_t fill_word(input int s, input int w);
		return 32'hC0DE_0000 | (32'(s) << 8) | 32'(w);
	endfunction

	function automatic wb_xbar_pkg::wb_dat_t merge_bytes(input wb_xbar_pkg::wb_dat_t old_dat,
			input wb_xbar_pkg::wb_dat_t new_dat, input wb_xbar_pkg::wb_sel_t sel);
		wb_xbar_pkg::wb_dat_t res;

		res = old_dat;
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) begin
				res[8*b +: 8] = new_dat[8*b +: 8];
			end
		end
		return res;
	endfunction

	// Random word-aligned address inside window s
	function automatic wb_xbar_pkg::wb_adr_t window_addr(input int s);
		return (32'(s) << 12) | ($urandom & 32'h0000_0FFC);
	endfunction

	// One transfer on master m, held until ack or err
	task automatic do_transfer(input int m, input logic we, input wb_xbar_pkg::wb_adr_t adr,
			input wb_xbar_pkg::wb_dat_t dat, input wb_xbar_pkg::wb_sel_t sel);
		int s;
		int w;

		s = int'(adr[13:12]);
		w = int'(adr[5:2]);
		exp_err[m] = (adr > 32'h0000_3FFF);
		exp_we[m] = we;
		exp_dat[m] = shadow[s][w];
		busy[m] = 1'b1;
		m_req[m] = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, sel: sel, dat_w: dat};
		do begin
			@(negedge clk);
		end while (!(m_rsp[m].ack || m_rsp[m].err));
		if (we && !exp_err[m]) begin
			shadow[s][w] = merge_bytes(shadow[s][w], dat, sel);
		end
		// Port samples the pulse on the next rising edge
		@(negedge clk);
		m_req[m] = '0;
		busy[m] = 1'b0;
		// Strobe stays low for one cycle before the next request
		@(negedge clk);
	endtask

	// Writes then reads on slave 2, words kept apart per master
	task automatic contend_master(input int m);
		wb_xbar_pkg::wb_adr_t adr;

		for (int k = 0; k < 4; k++) begin
			adr = 32'h0000_2000 | 32'((m * 8 + k) * 4);
			do_transfer(m, 1'b1, adr, $urandom, 4'hF);
		end
		for (int k = 0; k < 4; k++) begin
			adr = 32'h0000_2000 | 32'((m * 8 + k) * 4);
			do_transfer(m, 1'b0, adr, '0, 4'hF);
		end
	endtask

	// Slave strobes in total and per originating master
	always_comb begin
		stb_cnt = 0;
		for (int m = 0; m < wb_xbar_pkg::N_MASTERS; m++) begin
			from_cnt[m] = 0;
		end
		for (int s = 0; s < wb_xbar_pkg::N_SLAVES; s++) begin
			if (s_req[s].stb) begin
				stb_cnt = stb_cnt + 1;
			end
			for (int m = 0; m < wb_xbar_pkg::N_MASTERS; m++) begin
				if (s_req[s].stb && (s_req[s] == m_req[m])) begin
					from_cnt[m] = from_cnt[m] + 1;
				end
			end
		end
	end

	always @(posedge clk) begin
		cyc_cnt <= cyc_cnt + 1;
		if (cyc_cnt == CYCLE_LIMIT) begin
			abort_run("Timeout: the run did not finish within the cycle limit");
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			last_ack_q <= 1'b1;
			par_seen_q <= 1'b0;
		end else begin
			if (m_rsp[0].ack) begin
				last_ack_q <= 1'b0;
			end else if (m_rsp[1].ack) begin
				last_ack_q <= 1'b1;
			end
			if (stb_cnt == 2) begin
				par_seen_q <= 1'b1;
			end
		end
		for (int m = 0; m < wb_xbar_pkg::N_MASTERS; m++) begin
			if (!rstn || !m_req[m].stb) begin
				lat_q[m] <= '0;
			end else if (lat_q[m] != 8'hFF) begin
				lat_q[m] <= lat_q[m] + 8'd1;
			end
		end
	end

	for (genvar m = 0; m < wb_xbar_pkg::N_MASTERS; m++) begin : g_mchk
		// Quiet through reset and the first cycle after it
		assert property (@(posedge clk) (cyc_cnt >= 1 && cyc_cnt <= 9) |-> m_rsp[m] == '0)
			else report_mismatch("m_rsp in reset", '0, 128'(m_rsp[m]));
		assert property (@(posedge clk) disable iff (!rstn)
			(m_rsp[m].ack || m_rsp[m].err) |->
				{m_rsp[m].ack, m_rsp[m].err} == {!exp_err[m], exp_err[m]})
			else report_mismatch("ack and err", 128'({!exp_err[m], exp_err[m]}),
				128'({m_rsp[m].ack, m_rsp[m].err}));
		assert property (@(posedge clk) disable iff (!rstn)
			(m_rsp[m].ack && !exp_we[m]) |-> m_rsp[m].dat_r == exp_dat[m])
			else report_mismatch("read data", 128'(exp_dat[m]), 128'(m_rsp[m].dat_r));
		assert property (@(posedge clk) disable iff (!rstn)
			m_rsp[m].err |-> m_rsp[m].dat_r == '0)
			else report_mismatch("error data", '0, 128'(m_rsp[m].dat_r));
		// Three edges from first sampled strobe without contention
		assert property (@(posedge clk) disable iff (!rstn)
			((m_rsp[m].ack || m_rsp[m].err) && !contend) |-> lat_q[m] == 8'd3)
			else report_mismatch("latency", 128'(3), 128'(lat_q[m]));
		assert property (@(posedge clk) disable iff (!rstn)
			(contend && m_rsp[m].ack) |-> last_ack_q != 1'(m))
			else report_mismatch("acked master", 128'(!last_ack_q), 128'(m));
		assert property (@(posedge clk) disable iff (!rstn) from_cnt[m] <= 1)
			else report_mismatch("slaves with this strobe", 128'(1), 128'(from_cnt[m]));
	end

	for (genvar s = 0; s < wb_xbar_pkg::N_SLAVES; s++) begin : g_schk
		assert property (@(posedge clk) (cyc_cnt >= 1 && cyc_cnt <= 9) |-> s_req[s] == '0)
			else report_mismatch("s_req in reset", '0, 128'(s_req[s]));
		assert property (@(posedge clk) disable iff (!rstn)
			s_req[s].stb |-> s_req[s].adr[31:12] == 20'(s))
			else report_mismatch("slave window", 128'(s), 128'(s_req[s].adr[31:12]));
	end

	// Unmapped accesses never reach a slave
	assert property (@(posedge clk) disable iff (!rstn)
		((busy != 2'b00) && ((busy & exp_err) == busy)) |-> stb_cnt == 0)
		else report_mismatch("slave strobes", '0, 128'(stb_cnt));
	assert property (@(posedge clk) par_done |-> par_seen_q)
		else report_mismatch("parallel strobes", 128'(1), 128'(par_seen_q));

	initial begin
		wb_xbar_pkg::wb_adr_t adr_list [wb_xbar_pkg::N_MASTERS][8];

		void'($urandom(SEED));
		rstn = 1'b0;
		m_req[0] = '0;
		m_req[1] = '0;
		contend = 1'b0;
		par_done = 1'b0;
		busy = '0;
		exp_err = '0;
		exp_we = '0;
		exp_dat[0] = '0;
		exp_dat[1] = '0;
		for (int s = 0; s < wb_xbar_pkg::N_SLAVES; s++) begin
			for (int w = 0; w < MEM_WORDS; w++) begin
				shadow[s][w] = fill_word(s, w);
			end
		end
		test_name = "reset";
		repeat (8) @(posedge clk);
		@(negedge clk);
		rstn = 1'b1;
		@(negedge clk);

		// First after reset so master 0 must win the first round
		test_name = "contention";
		contend = 1'b1;
		fork
			contend_master(0);
			contend_master(1);
		join
		contend = 1'b0;
		@(negedge clk);

		test_name = "write_readback";
		for (int m = 0; m < wb_xbar_pkg::N_MASTERS; m++) begin
			for (int i = 0; i < 8; i++) begin
				adr_list[m][i] = window_addr(i % 4);
				do_transfer(m, 1'b1, adr_list[m][i], $urandom,
					wb_xbar_pkg::wb_sel_t'($urandom_range(15, 1)));
			end
			for (int i = 0; i < 8; i++) begin
				do_transfer(m, 1'b0, adr_list[m][i], '0, 4'hF);
			end
		end

		test_name = "decode_error";
		do_transfer(0, 1'b1, 32'h0000_4000 | $urandom, $urandom, 4'hF);
		do_transfer(0, 1'b0, 32'h0000_4000 | $urandom, '0, 4'hF);
		do_transfer(1, 1'b0, 32'hFFFF_FFFC, '0, 4'hF);

		// Slave 0 and slave 3 at the same time
		test_name = "parallel";
		for (int i = 0; i < 4; i++) begin
			adr_list[0][i] = window_addr(0);
			adr_list[1][i] = window_addr(3);
			fork
				do_transfer(0, 1'b1, adr_list[0][i], $urandom, 4'hF);
				do_transfer(1, 1'b1, adr_list[1][i], $urandom, 4'hF);
			join
		end
		for (int i = 0; i < 4; i++) begin
			fork
				do_transfer(0, 1'b0, adr_list[0][i], '0, 4'hF);
				do_transfer(1, 1'b0, adr_list[1][i], '0, 4'hF);
			join
		end
		par_done = 1'b1;
		repeat (2) @(negedge clk);

		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
source/wb_xbar_pkg.sv
source/wb_rr_arbiter.sv
source/wb_master_port.sv
source/wb_slave_port.sv
source/wb_decode_err.sv
source/wb_xbar_2x4.sv
verif/wb_mem_slave.sv
verif/tb_wb_xbar.sv

/* run_verilator.sh */
#!/bin/sh
# Build and run the crossbar testbench, exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f vlog.f --top-module tb_wb_xbar -o Vtb_wb_xbar &&
./obj_dir/Vtb_wb_xbar || exit 1
